// File: files.f
vec_pkg.sv
vec_skid_buf.sv
vec_elem_mul.sv
vec_reduce.sv
vec_dot_seq.sv
vec_dot_top.sv
vec_dot_checker.sv
vec_dot_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the dot-product testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module vec_dot_tb -o vec_dot_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/vec_dot_sim > sim.log 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status, see sim.log"
    exit 1
fi

if grep -q -F '*** PASSED ***' sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

// File: vec_dot_tb.sv
`timescale 1ns/100ps
`default_nettype none

module vec_dot_tb;

    import vec_pkg::*;

    localparam int WAIT_LIMIT = 400;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    a_vec_t      in_a;
    b_vec_t      in_b;
    logic        out_valid;
    logic        out_ready;
    prod_vec_t   out_prod;
    dot_t        out_dot;

    int          seed = 56;
    int          ready_seed;
    int          ready_mode;
    logic [31:0] ready_bits;
    logic [31:0] gap_bits;
    string       test_name;
    result_t     exp_q[$];
    result_t     exp_head;
    result_t     probe;

    vec_dot_top u_vec_dot_top (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_a(in_a), .in_b(in_b),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_prod(out_prod), .out_dot(out_dot)
    );

    always #5 clk = ~clk;

    // Each product is the signed product of same-index elements.
    function automatic result_t compute_expected(input a_vec_t a, input b_vec_t b);
        result_t r;
        int      p;
        int      sum;
        sum = 0;
        for (int i = 0; i < VEC_LEN; i++) begin
            p = int'($signed(a[i])) * int'($signed(b[i]));
            r.prod[i] = p[PROD_W-1:0];
            sum += p;
        end
        r.dot = sum[DOT_W-1:0];
        return r;
    endfunction

    function automatic a_vec_t random_vec();
        a_vec_t      v;
        logic [31:0] bits;
        for (int i = 0; i < VEC_LEN; i++) begin
            bits = $random(seed);
            v[i] = bits[A_W-1:0];
        end
        return v;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Fail %s: expected %0h, actual %0h",
                                    name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Leaves in_valid high so back-to-back pairs need no idle cycle.
    task automatic send_pair(input a_vec_t a, input b_vec_t b);
        int waited;
        waited = 0;
        in_valid = 1'b1;
        in_a = a;
        in_b = b;
        while (in_ready !== 1'b1) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_error($sformatf("Timed out waiting for in_ready in test %s",
                                        test_name));
            end
        end
        next_cycle();
    endtask

    task automatic send_random(input int count);
        for (int n = 0; n < count; n++) begin
            send_pair(random_vec(), random_vec());
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_error($sformatf("Results never arrived in test %s", test_name));
            end
        end
    endtask

    task automatic wait_in_stall();
        int waited;
        waited = 0;
        while (in_ready !== 1'b0) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_error("in_ready never dropped while the output was stalled");
            end
        end
    endtask

    task automatic wait_result_held();
        int waited;
        waited = 0;
        while (out_valid !== 1'b1 || in_ready !== 1'b1) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_error("No stalled result with free input appeared before reset");
            end
        end
    endtask

    // Output ready: 0 always high, 1 random, 2 always low.
    always @(posedge clk) begin
        #1;
        ready_bits = $random(ready_seed);
        if (ready_mode == 1) begin
            out_ready = ready_bits[0];
        end else begin
            out_ready = (ready_mode == 0);
        end
    end

    // Scoreboard, sampled mid-cycle where all signals are settled.
    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            exp_q.delete();
        end else begin
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    stop_on_error($sformatf("out_valid high with nothing pending in test %s",
                                            test_name));
                end else if (out_ready === 1'b1) begin
                    exp_head = exp_q.pop_front();
                    check_value({test_name, " prod"}, 128'(exp_head.prod), 128'(out_prod));
                    check_value({test_name, " dot"}, 128'(exp_head.dot), 128'(out_dot));
                end
            end
            if (in_valid === 1'b1 && in_ready === 1'b1) begin
                exp_q.push_back(compute_expected(in_a, in_b));
            end
        end
    end

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        in_a = '0;
        in_b = '0;
        out_ready = 1'b0;
        ready_mode = 0;
        ready_seed = seed + 1;
        test_name = "startup";
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "directed";
        probe = compute_expected({5{8'h01}}, {5{8'h01}});
        check_value("reference ones dot", 128'(5), 128'(probe.dot));
        probe = compute_expected({5{8'h80}}, {5{8'h80}});
        check_value("reference min prod", 128'(16384), 128'(probe.prod[0]));
        check_value("reference min dot", 128'(81920), 128'(probe.dot));
        send_pair({5{8'h01}}, {5{8'h01}});
        send_pair({8'h05, 8'hfc, 8'h03, 8'hfe, 8'h01}, {8'hfa, 8'h07, 8'hf8, 8'h09, 8'hf6});
        send_pair({5{8'h80}}, {5{8'h80}});
        send_pair({5{8'h80}}, {5{8'h7f}});
        in_valid = 1'b0;
        wait_drain();

        test_name = "random stream";
        send_random(200);
        wait_drain();

        test_name = "backpressure";
        ready_mode = 1;
        send_random(60);
        wait_drain();
        // Long stall fills both buffers and the sequencer.
        ready_mode = 2;
        send_random(5);
        wait_in_stall();
        ready_mode = 1;
        wait_drain();

        test_name = "input gaps";
        ready_mode = 0;
        for (int n = 0; n < 60; n++) begin
            send_pair(random_vec(), random_vec());
            in_valid = 1'b0;
            gap_bits = $random(seed);
            repeat (gap_bits[1:0]) next_cycle();
        end
        wait_drain();

        test_name = "reset in traffic";
        // First result waits at the output while the second job is inside.
        ready_mode = 2;
        send_random(2);
        wait_result_held();
        rst = 1'b1;
        next_cycle();
        check_value("reset out_valid", 128'(0), 128'(out_valid));
        check_value("reset in_ready", 128'(0), 128'(in_ready));
        repeat (9) next_cycle();
        rst = 1'b0;
        ready_mode = 0;
        send_random(20);
        wait_drain();

        test_name = "end of run";
        if (exp_q.size() != 0) begin
            stop_on_error("Expected results left over at end of run");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vec_dot_checker.sv
`timescale 1ns/100ps
`default_nettype none

module vec_dot_checker (
    input wire                     clk,
    input wire                     rst,
    input wire                     in_ready,
    input wire                     out_valid,
    input wire                     out_ready,
    input wire vec_pkg::prod_vec_t out_prod,
    input wire vec_pkg::dot_t      out_dot
);

    // A stalled result must hold still until it is taken.
    property p_out_hold;
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_prod) && $stable(out_dot));
    endproperty

    property p_reset_quiet;
        @(posedge clk) rst |=> (!out_valid && !in_ready);
    endproperty

    property p_no_x;
        @(posedge clk) disable iff (rst) !$isunknown({in_ready, out_valid});
    endproperty

    a_out_hold: assert property (p_out_hold)
        else $error("Output result changed while stalled");
    a_reset_quiet: assert property (p_reset_quiet)
        else $error("Handshake outputs high after reset");
    a_no_x: assert property (p_no_x)
        else $error("Unknown value on in_ready or out_valid");

endmodule

bind vec_dot_top vec_dot_checker u_checker (
    .clk(clk),
    .rst(rst),
    .in_ready(in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_prod(out_prod),
    .out_dot(out_dot)
);

`default_nettype wire

// File: vec_dot_top.sv
`timescale 1ns/100ps
`default_nettype none

module vec_dot_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 in_valid,
    output logic                in_ready,
    input  wire vec_pkg::a_vec_t in_a,
    input  wire vec_pkg::b_vec_t in_b,
    output logic                out_valid,
    input  wire                 out_ready,
    output vec_pkg::prod_vec_t  out_prod,
    output vec_pkg::dot_t       out_dot
);

    import vec_pkg::*;

    operand_t  in_op;
    operand_t  op_data;
    logic      op_valid;
    logic      op_ready;
    logic      mul_start;
    a_vec_t    mul_a;
    b_vec_t    mul_b;
    prod_vec_t mul_prod;
    logic      mul_valid;
    logic      red_valid;
    logic      red_done;
    dot_t      red_dot;
    prod_vec_t red_prod;
    logic      res_ready;
    result_t   res_in;
    result_t   res_out;

    assign in_op    = '{a: in_a, b: in_b};
    assign res_in   = '{prod: red_prod, dot: red_dot};
    assign out_prod = res_out.prod;
    assign out_dot  = res_out.dot;

    vec_skid_buf #(.payload_t(operand_t)) u_in_buf (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_op),
        .out_valid(op_valid), .out_ready(op_ready), .out_data(op_data)
    );

    vec_dot_seq u_seq (
        .clk(clk), .rst(rst),
        .op_valid(op_valid), .op_ready(op_ready),
        .op_a(op_data.a), .op_b(op_data.b),
        .mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b),
        .mul_valid(mul_valid),
        .red_valid(red_valid), .res_ready(res_ready), .red_done(red_done)
    );

    vec_elem_mul u_mul (
        .clk(clk), .rst(rst), .start(mul_start),
        .a(mul_a), .b(mul_b),
        .prod(mul_prod), .valid(mul_valid)
    );

    vec_reduce u_reduce (
        .clk(clk), .rst(rst),
        .in_valid(red_valid), .prod(mul_prod),
        .out_valid(red_done), .dot(red_dot), .prod_out(red_prod)
    );

    // Reduction output writes straight into the spare slot if needed.
    vec_skid_buf #(.payload_t(result_t)) u_out_buf (
        .clk(clk), .rst(rst),
        .in_valid(red_done), .in_ready(res_ready), .in_data(res_in),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(res_out)
    );

endmodule

`default_nettype wire

// File: vec_dot_seq.sv
`timescale 1ns/100ps
`default_nettype none

module vec_dot_seq (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 op_valid,
    output logic                op_ready,
    input  wire vec_pkg::a_vec_t op_a,
    input  wire vec_pkg::b_vec_t op_b,
    output logic                mul_start,
    output vec_pkg::a_vec_t     mul_a,
    output vec_pkg::b_vec_t     mul_b,
    input  wire                 mul_valid,
    output logic                red_valid,
    input  wire                 res_ready,
    input  wire                 red_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MUL,
        S_LAUNCH,
        S_DRAIN
    } state_t;

    state_t state;

    assign op_ready = (state == S_IDLE);

    // Output buffer has room, so the result can land two cycles on.
    assign red_valid = (state == S_LAUNCH) && res_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            mul_start <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (op_valid) begin
                        state     <= S_MUL;
                        mul_start <= 1'b1;
                    end
                end
                S_MUL: begin
                    // Valid is stale while start is still high.
                    if (!mul_start && mul_valid) begin
                        state <= S_LAUNCH;
                    end
                end
                S_LAUNCH: begin
                    if (res_ready) begin
                        state <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    if (red_done) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_ready) begin
            mul_a <= op_a;
            mul_b <= op_b;
        end
    end

endmodule

`default_nettype wire

// File: vec_reduce.sv
`timescale 1ns/100ps
`default_nettype none

module vec_reduce (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   in_valid,
    input  wire vec_pkg::prod_vec_t prod,
    output logic                  out_valid,
    output vec_pkg::dot_t         dot,
    output vec_pkg::prod_vec_t    prod_out
);

    import vec_pkg::*;

    dot_t      part_next [PAIR_N];
    dot_t      part_q    [PAIR_N];
    dot_t      sum_next;
    logic      mid_valid;
    prod_vec_t prod_mid;

    // Neighbouring products share a partial sum.
    always_comb begin
        for (int j = 0; j < PAIR_N; j++) begin
            part_next[j] = '0;
        end
        for (int k = 0; k < VEC_LEN; k++) begin
            part_next[k / 2] = part_next[k / 2] + dot_t'(signed'(prod[k]));
        end
    end

    always_comb begin
        sum_next = '0;
        for (int j = 0; j < PAIR_N; j++) begin
            sum_next = sum_next + part_q[j];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mid_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            mid_valid <= in_valid;
            out_valid <= mid_valid;
        end
    end

    always_ff @(posedge clk) begin
        part_q   <= part_next;
        prod_mid <= prod;
        dot      <= sum_next;
        prod_out <= prod_mid;
    end

endmodule

`default_nettype wire

// File: vec_elem_mul.sv
`timescale 1ns/100ps
`default_nettype none

module vec_elem_mul (
    input  wire                clk,
    input  wire                rst,
    input  wire                start,
    input  wire vec_pkg::a_vec_t a,
    input  wire vec_pkg::b_vec_t b,
    output vec_pkg::prod_vec_t prod,
    output logic               valid
);

    import vec_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_RUN
    } state_t;

    state_t               state;
    logic [MUL_IDX_W-1:0] idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            idx   <= '0;
            valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    idx <= '0;
                    if (start) begin
                        state <= S_RUN;
                        valid <= 1'b0;
                    end
                end
                S_RUN: begin
                    // Last tile reaches the end of the vector.
                    if (int'(idx) + TILING >= VEC_LEN) begin
                        idx   <= '0;
                        state <= S_IDLE;
                        valid <= 1'b1;
                    end else begin
                        idx <= idx + MUL_IDX_W'(TILING);
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // One tile of signed products per run cycle.
    always_ff @(posedge clk) begin
        if (state == S_RUN) begin
            for (int i = 0; i < TILING; i++) begin
                if (int'(idx) + i < VEC_LEN) begin
                    prod[int'(idx) + i] <= $signed(a[int'(idx) + i])
                                         * $signed(b[int'(idx) + i]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: vec_skid_buf.sv
`timescale 1ns/100ps
`default_nettype none

module vec_skid_buf #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,
    output logic          out_valid,
    input  wire           out_ready,
    output payload_t      out_data
);

    logic     spare_valid;
    payload_t spare_data;
    logic     wr;
    logic     rd;
    logic     spare_next;

    assign wr = in_valid && in_ready;
    assign rd = out_valid && out_ready;

    // Spare fills only when main is held and a new word arrives.
    assign spare_next = (spare_valid || (wr && out_valid)) && !rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            spare_valid <= 1'b0;
            in_ready    <= 1'b0;
        end else begin
            out_valid   <= spare_valid || wr || (out_valid && !rd);
            spare_valid <= spare_next;
            in_ready    <= !spare_next;
        end
    end

    // Main takes the older word first.
    always_ff @(posedge clk) begin
        if (!out_valid || rd) begin
            out_data <= spare_valid ? spare_data : in_data;
        end
        if (wr && out_valid && !rd) begin
            spare_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: vec_pkg.sv
`default_nettype none

package vec_pkg;

    localparam int VEC_LEN = 5;
    localparam int A_W     = 8;
    localparam int B_W     = 8;
    localparam int PROD_W  = 16;
    localparam int TILING  = 1;

    localparam int MUL_STEPS = (VEC_LEN + TILING - 1) / TILING;
    localparam int MUL_IDX_W = $clog2(MUL_STEPS * TILING);

    // Three guard bits cover the sum of five products.
    localparam int DOT_W  = PROD_W + 3;
    localparam int PAIR_N = (VEC_LEN + 1) / 2;

    typedef logic [VEC_LEN-1:0][A_W-1:0]    a_vec_t;
    typedef logic [VEC_LEN-1:0][B_W-1:0]    b_vec_t;
    typedef logic [VEC_LEN-1:0][PROD_W-1:0] prod_vec_t;
    typedef logic signed [DOT_W-1:0]        dot_t;

    typedef struct packed {
        a_vec_t a;
        b_vec_t b;
    } operand_t;

    typedef struct packed {
        prod_vec_t prod;
        dot_t      dot;
    } result_t;

endpackage

`default_nettype wire
